// File: udp_rx_macros.svh
// UDP receive constants: stream geometry, protocol codes and counter sizing

`ifndef UDP_RX_MACROS_SVH
`define UDP_RX_MACROS_SVH

// Avalon-ST beat width
`define UDP_RX_BEAT_BITS 256

// Fixed RPC payload carried in every frame
`define UDP_RX_PAYLOAD_BYTES 64

// IPv4 protocol number for UDP
`define UDP_RX_IP_PROTO_UDP 8'h11

// Only IPv4 is accepted
`define UDP_RX_IP_VERSION 4'h4

// All-ones destination MAC
`define UDP_RX_BROADCAST_MAC 48'hFFFF_FFFF_FFFF

// Drop counters and readout select
`define UDP_RX_CNT_BITS 32
`define UDP_RX_CNT_SEL_BITS 4

`endif

// File: udp_rx_pkg.sv
// UDP receive types: addresses, protocol headers, payload, beat and counters

`default_nettype none

`include "udp_rx_macros.svh"

package udp_rx_pkg;

    // ============================================================
    // Addresses
    // ============================================================
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;

    // ============================================================
    // Protocol headers, most significant byte first on the wire
    // ============================================================

    // 14 bytes
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        logic [15:0] length;
    } eth_hdr_t;

    // 20 bytes, no options
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  time_to_live;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        ipv4_addr_t  src_ip;
        ipv4_addr_t  dest_ip;
    } ip_hdr_t;

    // 8 bytes
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // ============================================================
    // Data path and readout
    // ============================================================
    typedef logic [`UDP_RX_PAYLOAD_BYTES*8-1:0] payload_t;
    typedef logic [`UDP_RX_BEAT_BITS-1:0]       beat_t;
    typedef logic [`UDP_RX_CNT_BITS-1:0]        cnt_t;

    // Readout index of each drop counter
    typedef enum logic [`UDP_RX_CNT_SEL_BITS-1:0] {
        CNT_TOTAL   = 4'd0,
        CNT_MAC     = 4'd1,
        CNT_IP      = 4'd2,
        CNT_PROTO   = 4'd3,
        CNT_VERSION = 4'd4
    } cnt_sel_e;

endpackage

`default_nettype wire

// File: udp_rx_beat_if.sv
// Per-beat capture strobes from the receive FSM to the data path

`timescale 1ns/1ps
`default_nettype none

interface udp_rx_beat_if;

    // Beat 1: Ethernet header and first 18 IPv4 header bytes
    logic hdr_head_take;
    // Beat 2: IPv4 header tail, UDP header, payload start
    logic hdr_tail_take;
    // Beat 3: middle 32 payload bytes
    logic body_take;
    // Beat 4 with end-of-packet
    logic last_take;

    modport fsm (
        output hdr_head_take,
        output hdr_tail_take,
        output body_take,
        output last_take
    );

    modport sink (
        input hdr_head_take,
        input hdr_tail_take,
        input body_take,
        input last_take
    );

endinterface

`default_nettype wire

// File: udp_rx_frame_fsm.sv
// Receive beat-position FSM with sticky end-of-packet framing error

`timescale 1ns/1ps
`default_nettype none

module udp_rx_frame_fsm (
    input  logic        rx_clk_in,
    input  logic        rx_reset_in,
    input  logic        rx_valid_in,
    input  logic        rx_sop_in,
    input  logic        rx_eop_in,
    udp_rx_beat_if.fsm  beats,
    output logic        framing_error
);

    typedef enum logic [1:0] {
        ST_HEAD,
        ST_TAIL,
        ST_BODY,
        ST_LAST
    } fsm_state_t;

    fsm_state_t state;

    // ============================================================
    // Take strobes qualified by valid
    // ============================================================
    assign beats.hdr_head_take = (state == ST_HEAD) && rx_valid_in && rx_sop_in;
    assign beats.hdr_tail_take = (state == ST_TAIL) && rx_valid_in;
    assign beats.body_take     = (state == ST_BODY) && rx_valid_in;
    assign beats.last_take     = (state == ST_LAST) && rx_valid_in && rx_eop_in;

    // One state per accepted beat
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            state <= ST_HEAD;
        end else begin
            if (beats.hdr_head_take) begin
                state <= ST_TAIL;
            end else if (beats.hdr_tail_take) begin
                state <= ST_BODY;
            end else if (beats.body_take) begin
                state <= ST_LAST;
            end else if (beats.last_take) begin
                state <= ST_HEAD;
            end
        end
    end

    // Sticky error on a beat 4 without EOP
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            framing_error <= 1'b0;
        end else if ((state == ST_LAST) && rx_valid_in && !rx_eop_in) begin
            framing_error <= 1'b1;
        end
    end

    // EOP only belongs on the fourth beat of a frame
    a_eop_on_last: assert property (
        @(posedge rx_clk_in) disable iff (rx_reset_in)
        (rx_valid_in && rx_eop_in) |-> (state == ST_LAST)
    );

endmodule

`default_nettype wire

// File: udp_rx_frame_capture.sv
// Header and payload capture at fixed beat offsets with frame delivery or drop

`timescale 1ns/1ps
`default_nettype none

module udp_rx_frame_capture import udp_rx_pkg::*; (
    input  logic        rx_clk_in,
    input  logic        rx_reset_in,
    input  beat_t       rx_data_in,
    udp_rx_beat_if.sink beats,
    input  logic        drop_frame,
    output logic        hdr_ready,
    output eth_hdr_t    eth_hdr,
    output ip_hdr_t     ip_hdr,
    output udp_hdr_t    udp_hdr,
    output logic        drop_pulse,
    output logic        pkt_valid,
    output payload_t    pkt_payload
);

    // ============================================================
    // Header registers
    // ============================================================
    always_ff @(posedge rx_clk_in) begin
        // Beat 1 carries the 14 byte Ethernet header and 18 IPv4 bytes
        if (beats.hdr_head_take) begin
            eth_hdr        <= rx_data_in[255:144];
            ip_hdr[159:16] <= rx_data_in[143:0];
        end
        // Beat 2 carries the last 2 IPv4 bytes and the 8 byte UDP header
        if (beats.hdr_tail_take) begin
            ip_hdr[15:0] <= rx_data_in[255:240];
            udp_hdr      <= rx_data_in[239:176];
        end
    end

    // ============================================================
    // Payload registers
    // ============================================================

    // 22 + 32 + 10 bytes over beats 2 to 4
    always_ff @(posedge rx_clk_in) begin
        if (beats.hdr_tail_take) begin
            pkt_payload[175:0] <= rx_data_in[175:0];
        end
        if (beats.body_take) begin
            pkt_payload[431:176] <= rx_data_in;
        end
        if (beats.last_take) begin
            pkt_payload[511:432] <= rx_data_in[79:0];
        end
    end

    // ============================================================
    // Control pulses
    // ============================================================
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            hdr_ready  <= 1'b0;
            pkt_valid  <= 1'b0;
            drop_pulse <= 1'b0;
        end else begin
            // Headers complete one cycle after beat 2
            hdr_ready  <= beats.hdr_tail_take;
            // drop_frame has settled by beat 4
            pkt_valid  <= beats.last_take && !drop_frame;
            drop_pulse <= beats.last_take && drop_frame;
        end
    end

    // Beat 4 arrives only after the drop decision is registered
    a_decision_settled: assert property (
        @(posedge rx_clk_in) disable iff (rx_reset_in)
        beats.last_take |-> !hdr_ready
    );

endmodule

`default_nettype wire

// File: udp_rx_header_check.sv
// Destination address, protocol and version checks with drop decision

`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_macros.svh"

module udp_rx_header_check import udp_rx_pkg::*; (
    input  logic       rx_clk_in,
    input  logic       rx_reset_in,
    input  mac_addr_t  host_mac,
    input  ipv4_addr_t host_ip,
    input  logic       hdr_ready,
    input  logic       hdr_head_take,
    input  eth_hdr_t   eth_hdr,
    input  ip_hdr_t    ip_hdr,
    output logic       drop_frame,
    output logic       mac_err,
    output logic       ip_err,
    output logic       proto_err,
    output logic       version_err
);

    logic mac_bad;
    logic ip_bad;
    logic proto_bad;
    logic version_bad;

    // ============================================================
    // Field compares
    // ============================================================
    assign mac_bad     = (eth_hdr.dest_mac != host_mac) &&
                         (eth_hdr.dest_mac != `UDP_RX_BROADCAST_MAC);
    assign ip_bad      = (ip_hdr.dest_ip != host_ip);
    assign proto_bad   = (ip_hdr.protocol != `UDP_RX_IP_PROTO_UDP);
    assign version_bad = (ip_hdr.version != `UDP_RX_IP_VERSION);

    // One cause pulse per failed check
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            mac_err     <= 1'b0;
            ip_err      <= 1'b0;
            proto_err   <= 1'b0;
            version_err <= 1'b0;
        end else begin
            mac_err     <= hdr_ready && mac_bad;
            ip_err      <= hdr_ready && ip_bad;
            proto_err   <= hdr_ready && proto_bad;
            version_err <= hdr_ready && version_bad;
        end
    end

    // Held until the next frame starts
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            drop_frame <= 1'b0;
        end else if (hdr_ready) begin
            drop_frame <= mac_bad || ip_bad || proto_bad || version_bad;
        end else if (hdr_head_take) begin
            drop_frame <= 1'b0;
        end
    end

    // Compared header and host fields are known when judged
    a_fields_known: assert property (
        @(posedge rx_clk_in) disable iff (rx_reset_in)
        hdr_ready |-> !$isunknown({eth_hdr.dest_mac, ip_hdr.dest_ip, ip_hdr.protocol,
                                   ip_hdr.version, host_mac, host_ip})
    );

endmodule

`default_nettype wire

// File: udp_rx_drop_counters.sv
// Wrapping drop counters per cause plus total with registered select readout

`timescale 1ns/1ps
`default_nettype none

module udp_rx_drop_counters import udp_rx_pkg::*; (
    input  logic     rx_clk_in,
    input  logic     rx_reset_in,
    input  logic     drop_pulse,
    input  logic     mac_err,
    input  logic     ip_err,
    input  logic     proto_err,
    input  logic     version_err,
    input  cnt_sel_e cnt_sel,
    input  logic     cnt_sel_valid,
    output cnt_t     cnt_value
);

    cnt_t total_cnt;
    cnt_t mac_cnt;
    cnt_t ip_cnt;
    cnt_t proto_cnt;
    cnt_t version_cnt;

    // ============================================================
    // Counters
    // ============================================================

    // Total counts frames and causes count failed checks
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            total_cnt   <= '0;
            mac_cnt     <= '0;
            ip_cnt      <= '0;
            proto_cnt   <= '0;
            version_cnt <= '0;
        end else begin
            if (drop_pulse)  total_cnt   <= total_cnt + cnt_t'(1);
            if (mac_err)     mac_cnt     <= mac_cnt + cnt_t'(1);
            if (ip_err)      ip_cnt      <= ip_cnt + cnt_t'(1);
            if (proto_err)   proto_cnt   <= proto_cnt + cnt_t'(1);
            if (version_err) version_cnt <= version_cnt + cnt_t'(1);
        end
    end

    // ============================================================
    // Readout
    // ============================================================

    // Unknown index reads zero
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            cnt_value <= '0;
        end else if (cnt_sel_valid) begin
            case (cnt_sel)
                CNT_TOTAL:   cnt_value <= total_cnt;
                CNT_MAC:     cnt_value <= mac_cnt;
                CNT_IP:      cnt_value <= ip_cnt;
                CNT_PROTO:   cnt_value <= proto_cnt;
                CNT_VERSION: cnt_value <= version_cnt;
                default:     cnt_value <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: udp_rx_top.sv
// UDP/IP receive path top level: framing, capture, header checks and drop counters

`timescale 1ns/1ps
`default_nettype none

module udp_rx_top import udp_rx_pkg::*; (
    input  logic        rx_clk_in,
    input  logic        rx_reset_in,
    input  mac_addr_t   host_mac,
    input  ipv4_addr_t  host_ip,
    input  beat_t       rx_data_in,
    input  logic        rx_valid_in,
    input  logic        rx_sop_in,
    input  logic        rx_eop_in,
    output logic        pkt_valid,
    output ipv4_addr_t  pkt_src_ip,
    output ipv4_addr_t  pkt_dest_ip,
    output logic [15:0] pkt_src_port,
    output logic [15:0] pkt_dest_port,
    output payload_t    pkt_payload,
    output logic        framing_error,
    input  cnt_sel_e    cnt_sel,
    input  logic        cnt_sel_valid,
    output cnt_t        cnt_value
);

    udp_rx_beat_if beats ();

    eth_hdr_t eth_hdr;
    ip_hdr_t  ip_hdr;
    udp_hdr_t udp_hdr;
    logic     hdr_ready;
    logic     drop_frame;
    logic     drop_pulse;
    logic     mac_err;
    logic     ip_err;
    logic     proto_err;
    logic     version_err;

    // Address tuple straight from the captured headers
    assign pkt_src_ip    = ip_hdr.src_ip;
    assign pkt_dest_ip   = ip_hdr.dest_ip;
    assign pkt_src_port  = udp_hdr.src_port;
    assign pkt_dest_port = udp_hdr.dest_port;

    udp_rx_frame_fsm i_frame_fsm (
        .rx_clk_in     (rx_clk_in),
        .rx_reset_in   (rx_reset_in),
        .rx_valid_in   (rx_valid_in),
        .rx_sop_in     (rx_sop_in),
        .rx_eop_in     (rx_eop_in),
        .beats         (beats.fsm),
        .framing_error (framing_error)
    );

    udp_rx_frame_capture i_frame_capture (
        .rx_clk_in   (rx_clk_in),
        .rx_reset_in (rx_reset_in),
        .rx_data_in  (rx_data_in),
        .beats       (beats.sink),
        .drop_frame  (drop_frame),
        .hdr_ready   (hdr_ready),
        .eth_hdr     (eth_hdr),
        .ip_hdr      (ip_hdr),
        .udp_hdr     (udp_hdr),
        .drop_pulse  (drop_pulse),
        .pkt_valid   (pkt_valid),
        .pkt_payload (pkt_payload)
    );

    udp_rx_header_check i_header_check (
        .rx_clk_in     (rx_clk_in),
        .rx_reset_in   (rx_reset_in),
        .host_mac      (host_mac),
        .host_ip       (host_ip),
        .hdr_ready     (hdr_ready),
        .hdr_head_take (beats.hdr_head_take),
        .eth_hdr       (eth_hdr),
        .ip_hdr        (ip_hdr),
        .drop_frame    (drop_frame),
        .mac_err       (mac_err),
        .ip_err        (ip_err),
        .proto_err     (proto_err),
        .version_err   (version_err)
    );

    udp_rx_drop_counters i_drop_counters (
        .rx_clk_in     (rx_clk_in),
        .rx_reset_in   (rx_reset_in),
        .drop_pulse    (drop_pulse),
        .mac_err       (mac_err),
        .ip_err        (ip_err),
        .proto_err     (proto_err),
        .version_err   (version_err),
        .cnt_sel       (cnt_sel),
        .cnt_sel_valid (cnt_sel_valid),
        .cnt_value     (cnt_value)
    );

endmodule

`default_nettype wire

// File: tb_udp_rx_top.sv
// Self-checking testbench for the UDP receive path driven from a frame table

`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_macros.svh"

module tb_udp_rx_top import udp_rx_pkg::*; ();

    localparam mac_addr_t  host_mac_cfg = 48'h02_00_5E_10_20_30;
    localparam ipv4_addr_t host_ip_cfg  = 32'hC0A8_0A01;
    localparam mac_addr_t  peer_mac     = 48'h02_00_5E_AA_BB_CC;
    localparam ipv4_addr_t peer_ip      = 32'hC0A8_0A37;
    localparam int         num_rows     = 9;
    localparam int         pkt_timeout  = 20;

    logic        rx_clk_in;
    logic        rx_reset_in;
    mac_addr_t   host_mac;
    ipv4_addr_t  host_ip;
    beat_t       rx_data_in;
    logic        rx_valid_in;
    logic        rx_sop_in;
    logic        rx_eop_in;
    logic        pkt_valid;
    ipv4_addr_t  pkt_src_ip;
    ipv4_addr_t  pkt_dest_ip;
    logic [15:0] pkt_src_port;
    logic [15:0] pkt_dest_port;
    payload_t    pkt_payload;
    logic        framing_error;
    cnt_sel_e    cnt_sel;
    logic        cnt_sel_valid;
    cnt_t        cnt_value;

    // One frame per row
    typedef struct packed {
        mac_addr_t   dest_mac;
        ipv4_addr_t  dest_ip;
        logic [7:0]  protocol;
        logic [3:0]  version;
        ipv4_addr_t  src_ip;
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic        drop_eop;
        logic        accept;
    } frame_row_t;

    frame_row_t rows [num_rows];
    // Index 0 total, then MAC, IP, protocol, version
    cnt_t       model_cnt [5];
    logic       model_framing;
    integer     seed;

    udp_rx_top i_udp_rx_top (
        .rx_clk_in     (rx_clk_in),
        .rx_reset_in   (rx_reset_in),
        .host_mac      (host_mac),
        .host_ip       (host_ip),
        .rx_data_in    (rx_data_in),
        .rx_valid_in   (rx_valid_in),
        .rx_sop_in     (rx_sop_in),
        .rx_eop_in     (rx_eop_in),
        .pkt_valid     (pkt_valid),
        .pkt_src_ip    (pkt_src_ip),
        .pkt_dest_ip   (pkt_dest_ip),
        .pkt_src_port  (pkt_src_port),
        .pkt_dest_port (pkt_dest_port),
        .pkt_payload   (pkt_payload),
        .framing_error (framing_error),
        .cnt_sel       (cnt_sel),
        .cnt_sel_valid (cnt_sel_valid),
        .cnt_value     (cnt_value)
    );

    initial begin
        rx_clk_in = 1'b0;
        forever #50 rx_clk_in = ~rx_clk_in;
    end

    // ============================================================
    // Reporting and compares
    // ============================================================
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0t: %s is %b, expected %b",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_cnt(input cnt_sel_e sel, input cnt_t expected);
        if (cnt_value !== expected) begin
            abort_run($sformatf("Error at %0t: counter %0d reads %0d, expected %0d",
                                $time, sel, cnt_value, expected));
        end
    endtask

    task automatic check_pkt(input ipv4_addr_t src_ip, input ipv4_addr_t dest_ip,
                             input logic [15:0] src_port, input logic [15:0] dest_port,
                             input payload_t payload);
        if ({pkt_src_ip, pkt_dest_ip} !== {src_ip, dest_ip}) begin
            abort_run($sformatf("Error at %0t: IP pair %h/%h, expected %h/%h",
                                $time, pkt_src_ip, pkt_dest_ip, src_ip, dest_ip));
        end
        if ({pkt_src_port, pkt_dest_port} !== {src_port, dest_port}) begin
            abort_run($sformatf("Error at %0t: ports %0d/%0d, expected %0d/%0d",
                                $time, pkt_src_port, pkt_dest_port, src_port, dest_port));
        end
        if (pkt_payload !== payload) begin
            abort_run($sformatf("Error at %0t: payload %h, expected %h",
                                $time, pkt_payload, payload));
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic load_table();
        rows[0] = '{host_mac_cfg, host_ip_cfg, `UDP_RX_IP_PROTO_UDP, `UDP_RX_IP_VERSION,
                    peer_ip, 16'd5001, 16'd7000, 1'b0, 1'b1};
        rows[1] = '{`UDP_RX_BROADCAST_MAC, host_ip_cfg, `UDP_RX_IP_PROTO_UDP,
                    `UDP_RX_IP_VERSION, 32'h0A00_0002, 16'd6100, 16'd7001, 1'b0, 1'b1};
        rows[2] = '{48'h02_00_5E_10_20_31, host_ip_cfg, `UDP_RX_IP_PROTO_UDP,
                    `UDP_RX_IP_VERSION, peer_ip, 16'd5002, 16'd7000, 1'b0, 1'b0};
        rows[3] = '{host_mac_cfg, 32'hC0A8_0A02, `UDP_RX_IP_PROTO_UDP, `UDP_RX_IP_VERSION,
                    peer_ip, 16'd5003, 16'd7000, 1'b0, 1'b0};
        rows[4] = '{host_mac_cfg, host_ip_cfg, 8'h06, `UDP_RX_IP_VERSION,
                    peer_ip, 16'd5004, 16'd7000, 1'b0, 1'b0};
        rows[5] = '{host_mac_cfg, host_ip_cfg, `UDP_RX_IP_PROTO_UDP, 4'h6,
                    peer_ip, 16'd5005, 16'd7000, 1'b0, 1'b0};
        // Two bad fields in one frame
        rows[6] = '{peer_mac, 32'h0A0B_0C0D, `UDP_RX_IP_PROTO_UDP, `UDP_RX_IP_VERSION,
                    peer_ip, 16'd5006, 16'd7000, 1'b0, 1'b0};
        rows[7] = '{host_mac_cfg, host_ip_cfg, `UDP_RX_IP_PROTO_UDP, `UDP_RX_IP_VERSION,
                    peer_ip, 16'd5007, 16'd7002, 1'b1, 1'b1};
        rows[8] = '{`UDP_RX_BROADCAST_MAC, host_ip_cfg, `UDP_RX_IP_PROTO_UDP,
                    `UDP_RX_IP_VERSION, peer_ip, 16'd5008, 16'd7003, 1'b0, 1'b1};
    endtask

    task automatic fill_payload(output payload_t pl);
        for (int i = 0; i < `UDP_RX_PAYLOAD_BYTES / 4; i++) begin
            pl[i*32 +: 32] = $random(seed);
        end
    endtask

    task automatic fill_beat(output beat_t b);
        for (int i = 0; i < `UDP_RX_BEAT_BITS / 32; i++) begin
            b[i*32 +: 32] = $random(seed);
        end
    endtask

    // Fixed layout of the four beats with filler in the unused bits of beat 4
    task automatic build_beats(input frame_row_t row, input payload_t pl, input beat_t filler,
                               output beat_t b1, output beat_t b2,
                               output beat_t b3, output beat_t b4);
        eth_hdr_t eth;
        ip_hdr_t  ip;
        udp_hdr_t udp;
        eth.dest_mac    = row.dest_mac;
        eth.src_mac     = peer_mac;
        eth.length      = 16'h0800;
        ip              = '0;
        ip.version      = row.version;
        ip.ihl          = 4'd5;
        ip.length       = 16'd92;
        ip.time_to_live = 8'd64;
        ip.protocol     = row.protocol;
        ip.src_ip       = row.src_ip;
        ip.dest_ip      = row.dest_ip;
        udp.src_port    = row.src_port;
        udp.dest_port   = row.dest_port;
        udp.length      = 16'd72;
        udp.checksum    = 16'h0000;
        // First 18 IPv4 bytes in beat 1, the last 2 lead beat 2
        b1 = {eth, ip[159:16]};
        b2 = {ip[15:0], udp, pl[175:0]};
        b3 = pl[431:176];
        b4 = {filler[255:80], pl[511:432]};
    endtask

    // Called 1 ns past a rising edge and returns 1 ns past the capturing edge
    task automatic send_beat(input beat_t data, input logic sop, input logic eop);
        rx_data_in  = data;
        rx_valid_in = 1'b1;
        rx_sop_in   = sop;
        rx_eop_in   = eop;
        @(posedge rx_clk_in);
        #1;
        rx_valid_in = 1'b0;
        rx_sop_in   = 1'b0;
        rx_eop_in   = 1'b0;
    endtask

    task automatic idle_gap();
        int unsigned gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
            @(posedge rx_clk_in);
            #1;
        end
    endtask

    task automatic run_frame(input frame_row_t row);
        payload_t pl;
        beat_t    filler;
        beat_t    b1;
        beat_t    b2;
        beat_t    b3;
        beat_t    b4;
        logic     mac_bad;
        logic     ip_bad;
        logic     proto_bad;
        logic     version_bad;
        int       waited;
        fill_payload(pl);
        fill_beat(filler);
        build_beats(row, pl, filler, b1, b2, b3, b4);
        mac_bad     = (row.dest_mac != host_mac_cfg) && (row.dest_mac != `UDP_RX_BROADCAST_MAC);
        ip_bad      = (row.dest_ip != host_ip_cfg);
        proto_bad   = (row.protocol != `UDP_RX_IP_PROTO_UDP);
        version_bad = (row.version != `UDP_RX_IP_VERSION);
        if (row.accept == (mac_bad || ip_bad || proto_bad || version_bad)) begin
            abort_run("Stimulus table row disagrees with the header rules");
        end
        check_flag("pkt_valid before frame", 1'b0, pkt_valid);
        send_beat(b1, 1'b1, 1'b0);
        idle_gap();
        send_beat(b2, 1'b0, 1'b0);
        idle_gap();
        send_beat(b3, 1'b0, 1'b0);
        idle_gap();
        if (row.drop_eop) begin
            // Beat 4 without end-of-packet is not captured
            send_beat(filler, 1'b0, 1'b0);
            model_framing = 1'b1;
            idle_gap();
        end
        send_beat(b4, 1'b0, 1'b1);
        if (row.accept) begin
            waited = 0;
            while (!pkt_valid && waited < pkt_timeout) begin
                @(posedge rx_clk_in);
                #1;
                waited++;
            end
            if (!pkt_valid) begin
                abort_run("Timeout: the packet never arrived on pkt_valid");
            end
            if (waited != 0) begin
                abort_run($sformatf("Error at %0t: pkt_valid came %0d cycles late",
                                    $time, waited));
            end
            check_pkt(row.src_ip, row.dest_ip, row.src_port, row.dest_port, pl);
            @(posedge rx_clk_in);
            #1;
            check_flag("pkt_valid one cycle wide", 1'b0, pkt_valid);
            check_pkt(row.src_ip, row.dest_ip, row.src_port, row.dest_port, pl);
        end else begin
            check_flag("pkt_valid on dropped frame", 1'b0, pkt_valid);
            repeat (3) begin
                @(posedge rx_clk_in);
                #1;
                check_flag("pkt_valid on dropped frame", 1'b0, pkt_valid);
            end
            model_cnt[0] = model_cnt[0] + 32'd1;
        end
        if (mac_bad) model_cnt[1] = model_cnt[1] + 32'd1;
        if (ip_bad) model_cnt[2] = model_cnt[2] + 32'd1;
        if (proto_bad) model_cnt[3] = model_cnt[3] + 32'd1;
        if (version_bad) model_cnt[4] = model_cnt[4] + 32'd1;
        check_flag("framing_error", model_framing, framing_error);
    endtask

    // Index 9 is outside the counter map
    task automatic read_counters();
        int       idx_list [6];
        cnt_sel_e sel;
        cnt_t     expected;
        idx_list = '{0, 1, 2, 3, 4, 9};
        foreach (idx_list[k]) begin
            sel           = cnt_sel_e'(idx_list[k][3:0]);
            expected      = (idx_list[k] < 5) ? model_cnt[idx_list[k]] : '0;
            cnt_sel       = sel;
            cnt_sel_valid = 1'b1;
            @(posedge rx_clk_in);
            #1;
            cnt_sel_valid = 1'b0;
            check_cnt(sel, expected);
            // Readout holds while the select moves without a strobe
            cnt_sel = cnt_sel_e'(4'd15);
            @(posedge rx_clk_in);
            #1;
            check_cnt(sel, expected);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        seed          = 32'h9d6d20b6;
        model_framing = 1'b0;
        for (int i = 0; i < 5; i++) begin
            model_cnt[i] = '0;
        end
        rx_reset_in   = 1'b1;
        host_mac      = host_mac_cfg;
        host_ip       = host_ip_cfg;
        rx_data_in    = '0;
        rx_valid_in   = 1'b0;
        rx_sop_in     = 1'b0;
        rx_eop_in     = 1'b0;
        cnt_sel       = CNT_TOTAL;
        cnt_sel_valid = 1'b0;
        load_table();
        repeat (3) @(posedge rx_clk_in);
        #1;
        rx_reset_in = 1'b0;
        check_flag("pkt_valid after reset", 1'b0, pkt_valid);
        check_flag("framing_error after reset", 1'b0, framing_error);
        check_cnt(CNT_TOTAL, '0);
        for (int r = 0; r < num_rows; r++) begin
            run_frame(rows[r]);
            read_counters();
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_rx.f
+incdir+.
udp_rx_pkg.sv
udp_rx_beat_if.sv
udp_rx_frame_fsm.sv
udp_rx_frame_capture.sv
udp_rx_header_check.sv
udp_rx_drop_counters.sv
udp_rx_top.sv
tb_udp_rx_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the UDP receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f udp_rx.f \
    --top-module tb_udp_rx_top \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_udp_rx_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi
